// ==== list.f ====
+incdir+hw
hw/gem_cluster_pkg.sv
hw/trg_tx_pkg.sv
hw/txpll_reset_gen.sv
hw/prbs7_gen.sv
hw/gem_fiber_out.sv
hw/trigger_links.sv
testbench/tb_clock_gen.sv
testbench/tb_trigger_links.sv

// ==== testbench/tb_trigger_links.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trg_link_defs.svh"

module tb_trigger_links
  import gem_cluster_pkg::*;
  import trg_tx_pkg::*;
();

  localparam int C0         = `TRG_PLL_RST_CYCLES + `TRG_PLL_LOCK_CYCLES;  // First linked cycle
  localparam int N_BURST    = 40;       // Sets offered every crossing
  localparam int N_GAPPED   = 20;       // Sets behind random idle gaps
  localparam int PLANNED_BX = 2 * (C0 / 4 + 4) + N_BURST + 4 * N_GAPPED + 16;

  typedef struct packed {
    logic         valid;                // Frame carries a captured set
    cluster_set_t data;
  } frame_t;

  logic         clk_160;
  logic         arst_n;
  cluster_set_t clusters;
  logic         req;
  logic         ack;
  logic         test_pat_en;
  logic         link_ready;
  lane_bus_t    lanes;
  logic [3:0]   ltncy_trig;

  int           cyc;                    // Cycles since arst_n release
  logic         ack_exp;
  logic         ack_seen;               // ack sampled mid-cycle, for the driver
  logic [6:0]   prbs_state;
  tx_word_t     prbs_cur;               // PRBS word due on the lanes next cycle
  frame_t       cur_frame;
  frame_t       frames[$];              // Expected frames in send order
  int           offered  = 0;
  int           sent     = 0;           // Data frames fully compared on the lanes

  tb_clock_gen #(.PERIOD_NS(10)) u_clk (.clk(clk_160));

  trigger_links uut (
    .clk_160     (clk_160),
    .arst_n      (arst_n),
    .clusters    (clusters),
    .req         (req),
    .ack         (ack),
    .test_pat_en (test_pat_en),
    .link_ready  (link_ready),
    .lanes       (lanes),
    .ltncy_trig  (ltncy_trig)
  );

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic tx_char_t ref_char(input int lane, input int idx, input frame_t f,
                                        input logic test, input tx_word_t prbs);
    tx_char_t      c;
    link_payload_t pl;
    logic          sync;
    c.data = {`TRG_COMMA, `TRG_COMMA};                 // Idle character
    c.isk  = 2'b11;
    if (lane % 2 == 0) begin
      pl = {f.data.cluster[3], f.data.cluster[2], f.data.cluster[1], f.data.cluster[0]};
    end else begin
      pl = {f.data.cluster[7], f.data.cluster[6], f.data.cluster[5], f.data.cluster[4]};
    end
    sync = (f.data.bxn[6:0] == 7'd0);                  // Comma every 128 crossings
    if (test) begin
      c.data = prbs;
      c.isk  = 2'b00;
    end else if (f.valid && idx == 0) begin
      c.data = {sync ? `TRG_COMMA : {f.data.overflow, f.data.bxn[6:0]}, pl[55:48]};
      c.isk  = {sync, 1'b0};
    end else if (f.valid) begin
      c.data = pl[63 - 16 * idx -: 16];                // MSB first after the header
      c.isk  = 2'b00;
    end
    return c;
  endfunction

  // Sixteen steps of x^7+x^6+1, returns {next state, word}
  function automatic logic [22:0] prbs_step(input logic [6:0] state);
    logic [6:0] s;
    tx_word_t   w;
    logic       fb;
    s = state;
    for (int i = 15; i >= 0; i--) begin
      fb   = s[6] ^ s[5];
      w[i] = fb;                                       // Earliest bit in the MSB
      s    = {s[5:0], fb};
    end
    return {s, w};
  endfunction

  function automatic cluster_set_t random_set(input bit sync_bx);
    cluster_set_t s;
    for (int i = 0; i < `TRG_CLUSTERS; i++) begin
      s.cluster[i] = 14'($urandom);
    end
    s.bxn      = 12'($urandom);
    s.overflow = 1'($urandom);
    if (sync_bx) begin
      s.bxn[6:0] = 7'd0;                               // Forces a comma header
    end
    return s;
  endfunction

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_char(input string name, input tx_char_t exp, input tx_char_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail t=%0t %s expected %h/%b actual %h/%b", $time, name,
                          exp.data, exp.isk, act.data, act.isk));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Fail t=%0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // Mid-cycle compare of every output, then the model steps to the next cycle
  always @(negedge clk_160) begin : compare_outputs
    int       r;
    int       j;
    logic     cap;
    frame_t   nxt;
    tx_char_t exp_char;
    if (!arst_n) begin
      cyc        = 0;
      ack_exp    = 1'b0;
      prbs_state = '1;
      cur_frame  = '0;
      frames.delete();
      frames.push_back(cur_frame);                     // Frame 0 is always idle
      r = -1;
    end else begin
      r = cyc - C0;
    end
    ack_seen = ack;
    if (r >= 1 && (r - 1) % 4 == 0) begin
      if (frames.size() == 0) begin
        abort_run("Expected frame queue ran empty at a frame start");
      end else begin
        cur_frame = frames.pop_front();
      end
    end
    j = (r >= 1) ? (r - 1) % 4 : 0;
    check_bit("pll_rst", !arst_n || cyc < `TRG_PLL_RST_CYCLES, uut.pll_rst);
    check_bit("link_ready", arst_n && cyc >= C0, link_ready);
    check_bit("ack", ack_exp, ack);
    for (int i = 0; i < `TRG_LANES; i++) begin
      exp_char = ref_char(i, j, cur_frame, test_pat_en && r >= 1, prbs_cur);
      check_char($sformatf("lanes[%0d]", i), exp_char, lanes[i]);
      check_bit($sformatf("ltncy_trig[%0d]", i), !test_pat_en && r >= 1 && j == 0 &&
                cur_frame.valid && cur_frame.data.bxn[6:0] == 7'd0, ltncy_trig[i]);
    end
    if (r >= 1 && j == 3 && cur_frame.valid) begin
      sent++;                                          // Last character of a data frame
    end
    if (arst_n) begin
      if (r >= 0) begin
        {prbs_state, prbs_cur} = prbs_step(prbs_state);
      end
      cap = (r >= 0) && (r % 4 == 3) && req && !ack_exp;   // Four-phase capture rule
      if (r >= 0 && r % 4 == 3) begin
        nxt.valid = cap;
        nxt.data  = clusters;
        frames.push_back(nxt);                         // Goes out next crossing
      end
      if (cap) begin
        ack_exp = 1'b1;
      end else if (ack_exp && !req) begin
        ack_exp = 1'b0;
      end
      cyc++;
    end
  end

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  task automatic apply_reset(input logic test_mode);
    arst_n      <= 1'b0;
    req         <= 1'b0;
    test_pat_en <= test_mode;                          // Only changes under reset
    repeat (5) @(posedge clk_160);
    arst_n      <= 1'b1;
  endtask

  task automatic offer_set(input cluster_set_t s, input int delay);
    repeat (delay) @(posedge clk_160);
    req      <= 1'b1;
    clusters <= s;
    do @(posedge clk_160); while (!ack_seen);
    req      <= 1'b0;
    offered++;
    do @(posedge clk_160); while (ack_seen);           // ack low before next req
  endtask

  initial begin : stimulus
    int unsigned seed;
    int          rnd;
    seed        = 32'h952a_f94d;
    rnd         = $urandom(seed);
    arst_n      = 1'b0;
    req         = 1'b0;
    clusters    = '0;
    test_pat_en = 1'b0;
    @(posedge clk_160);
    apply_reset(1'b0);
    for (int i = 0; i < N_BURST; i++) begin
      offer_set(random_set(i % 8 == 3), 0);            // One set per crossing
    end
    for (int i = 0; i < N_GAPPED; i++) begin
      offer_set(random_set(i % 5 == 1), $urandom % 10);  // Idle BX and late req
    end
    repeat (16) @(posedge clk_160);
    @(posedge clk_160);
    apply_reset(1'b1);                                 // PRBS from c0 on
    repeat (C0 + 64) @(posedge clk_160);
    if (sent != offered) begin
      abort_run($sformatf("Only %0d of %0d offered sets went out on the lanes",
                          sent, offered));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  initial begin : watchdog
    #(PLANNED_BX * 4 * 10 + 2000);
    abort_run("Timeout, the test did not finish in the planned time");
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 10     // Testbench stand-in for clk_160
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;   // Free running, 50 % duty

endmodule

`default_nettype wire

// ==== hw/trigger_links.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trg_link_defs.svh"

module trigger_links
  import gem_cluster_pkg::*;
  import trg_tx_pkg::*;
(
  input  logic           clk_160,
  input  logic           arst_n,
  input  cluster_set_t   clusters,
  input  logic           req,
  output logic           ack,
  input  logic           test_pat_en,
  output logic           link_ready,
  output lane_bus_t      lanes,
  output logic [3:0]     ltncy_trig
);

  localparam logic [1:0] LAST_PHASE = 2'(`TRG_WORDS_PER_BX - 1);

  logic          pll_rst;
  logic [1:0]    phase;          // Character slot within the crossing
  logic          capture;        // Set taken at the end of this cycle
  cluster_set_t  set_q;          // Set being framed this crossing
  logic          set_valid;      // set_q holds a real set
  link_payload_t link_r;
  link_payload_t link_l;
  link_payload_t link [`TRG_LANES];

  txpll_reset_gen u_txpll_rst (
    .clk_160    (clk_160),
    .arst_n     (arst_n),
    .pll_rst    (pll_rst),
    .link_ready (link_ready)
  );

  // ---------------------------------------------------------------------------
  // Crossing phase, four clk_160 cycles per BX
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_160 or negedge arst_n) begin
    if (!arst_n) begin
      phase <= 2'd0;
    end else if (!link_ready) begin
      phase <= 2'd0;                                  // Parked until lock
    end else begin
      phase <= (phase == LAST_PHASE) ? 2'd0 : phase + 2'd1;
    end
  end

  // ---------------------------------------------------------------------------
  // Cluster input, four-phase req/ack
  // ---------------------------------------------------------------------------
  assign capture = (phase == LAST_PHASE) && req && !ack;   // At most one per BX

  always_ff @(posedge clk_160 or negedge arst_n) begin
    if (!arst_n) begin
      ack       <= 1'b0;
      set_valid <= 1'b0;
    end else begin
      if (capture) begin
        ack <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;                                  // Drops once req seen low
      end
      if (pll_rst) begin
        set_valid <= 1'b0;                            // Nothing stale across a PLL reset
      end else if (phase == LAST_PHASE) begin
        set_valid <= capture;                         // Empty BX gives an idle frame
      end
    end
  end

  always_ff @(posedge clk_160) begin
    if (capture) begin
      set_q <= clusters;                              // Stable while req is high
    end
  end

  // ---------------------------------------------------------------------------
  // Lane mapping, CSC and GEM copies of each side
  // ---------------------------------------------------------------------------
  assign link_r  = set_q.cluster[3:0];                // Clusters 3..0
  assign link_l  = set_q.cluster[7:4];                // Clusters 7..4

  assign link[0] = link_r;                            // CSC right
  assign link[1] = link_l;                            // CSC left
  assign link[2] = link_r;                            // GEM right
  assign link[3] = link_l;                            // GEM left

  for (genvar i = 0; i < `TRG_LANES; i++) begin : g_lane
    gem_fiber_out u_fiber (
      .clk_160     (clk_160),
      .arst_n      (arst_n),
      .payload     (link[i]),
      .bxn         (set_q.bxn),
      .overflow    (set_q.overflow),
      .frame_valid (set_valid),
      .phase       (phase),
      .test_pat_en (test_pat_en),
      .link_ready  (link_ready),
      .tx_char     (lanes[i]),
      .ltncy_trig  (ltncy_trig[i])
    );
  end

endmodule

`default_nettype wire

// ==== hw/gem_fiber_out.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trg_link_defs.svh"

module gem_fiber_out
  import gem_cluster_pkg::*;
  import trg_tx_pkg::*;
(
  input  logic          clk_160,
  input  logic          arst_n,
  input  link_payload_t payload,
  input  bxn_t          bxn,
  input  logic          overflow,
  input  logic          frame_valid,
  input  logic [1:0]    phase,
  input  logic          test_pat_en,
  input  logic          link_ready,
  output tx_char_t      tx_char,
  output logic          ltncy_trig
);

  localparam int SYNC_BITS = $clog2(`TRG_SYNC_PERIOD);   // Low bxn bits that pick the comma

  frame_state_e state_q;
  frame_state_e state_d;
  tx_word_t     prbs_word;     // Test pattern for this cycle
  tx_word_t     body_word;     // Payload slice for characters 1..3
  logic         sync_bx;       // Crossing gets a comma header
  logic [7:0]   hdr_byte;
  tx_char_t     char_d;        // Character loaded into the output register

  prbs7_gen u_prbs (
    .clk_160 (clk_160),
    .arst_n  (arst_n),
    .restart (~link_ready),    // Held at all ones until c0
    .pattern (prbs_word)
  );

  // ---------------------------------------------------------------------------
  // Header byte
  // ---------------------------------------------------------------------------
  assign sync_bx  = (bxn[SYNC_BITS-1:0] == '0);                  // Once per sync period
  assign hdr_byte = sync_bx ? `TRG_COMMA : {overflow, bxn[SYNC_BITS-1:0]};

  // ---------------------------------------------------------------------------
  // Frame sequencing, one character per phase
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    if (!link_ready) begin
      state_d = idle;                                // Link not up yet
    end else if (phase == 2'd0) begin
      state_d = frame_valid ? header : idle;         // Frame start
    end else if (state_q != idle) begin
      state_d = body;                                // Rest of a data frame
    end
  end

  // Payload goes out most significant first after the header
  always_comb begin
    unique case (phase)
      2'd1:    body_word = payload[47:32];
      2'd2:    body_word = payload[31:16];
      2'd3:    body_word = payload[15:0];
      default: body_word = payload[55:40];         // Not a body phase
    endcase
  end

  always_comb begin
    char_d.data = {`TRG_COMMA, `TRG_COMMA};          // Idle filler
    char_d.isk  = 2'b11;
    unique case (state_d)
      header: begin
        char_d.data = {hdr_byte, payload[55:48]};
        char_d.isk  = {sync_bx, 1'b0};               // K only on a comma header
      end
      body: begin
        char_d.data = body_word;
        char_d.isk  = 2'b00;
      end
      default: ;
    endcase
    if (test_pat_en && link_ready) begin
      char_d.data = prbs_word;                       // PRBS overrides all lane data
      char_d.isk  = 2'b00;
    end
  end

  // ---------------------------------------------------------------------------
  // Output register, the single cycle of latency
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_160 or negedge arst_n) begin
    if (!arst_n) begin
      state_q      <= idle;
      tx_char.data <= {`TRG_COMMA, `TRG_COMMA};      // Lane idles on commas
      tx_char.isk  <= 2'b11;
      ltncy_trig   <= 1'b0;
    end else begin
      state_q      <= state_d;
      tx_char      <= char_d;
      // Marks the comma header as it leaves, none in test mode
      ltncy_trig   <= (state_d == header) && sync_bx && !test_pat_en;
    end
  end

endmodule

`default_nettype wire

// ==== hw/prbs7_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs7_gen
  import trg_tx_pkg::*;
(
  input  logic     clk_160,
  input  logic     arst_n,
  input  logic     restart,
  output tx_word_t pattern
);

  localparam int STEPS = $bits(tx_word_t);   // One LFSR step per output bit

  logic [6:0] lfsr_q;
  logic [6:0] lfsr_d;

  // ---------------------------------------------------------------------------
  // Sixteen steps of x^7 + x^6 + 1 unrolled per clock
  // ---------------------------------------------------------------------------
  always_comb begin : step_lfsr
    logic [6:0] s;
    logic       fb;
    s       = lfsr_q;
    fb      = 1'b0;
    pattern = '0;
    for (int i = STEPS - 1; i >= 0; i--) begin
      fb         = s[6] ^ s[5];    // Taps at 7 and 6
      pattern[i] = fb;             // Earliest bit lands in the MSB
      s          = {s[5:0], fb};
    end
    lfsr_d = s;
  end

  always_ff @(posedge clk_160 or negedge arst_n) begin
    if (!arst_n) begin
      lfsr_q <= '1;                // All ones, never the lockup state
    end else if (restart) begin
      lfsr_q <= '1;                // Reseed, sequence starts over
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/txpll_reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trg_link_defs.svh"

module txpll_reset_gen (
  input  logic clk_160,
  input  logic arst_n,
  output logic pll_rst,
  output logic link_ready
);

  localparam int RST_CYCLES  = `TRG_PLL_RST_CYCLES;
  localparam int DONE_COUNT  = `TRG_PLL_RST_CYCLES + `TRG_PLL_LOCK_CYCLES;
  localparam int CNT_W       = $clog2(DONE_COUNT + 1);

  logic [CNT_W-1:0] cnt_q;   // Cycles since arst_n release, saturating

  always_ff @(posedge clk_160 or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;                             // Sequence restarts on every reset
    end else if (cnt_q != CNT_W'(DONE_COUNT)) begin
      cnt_q <= cnt_q + CNT_W'(1);              // Stops once lock is reached
    end
  end

  // PLL held in reset for the first cycles, like the old SRL16 stretcher
  assign pll_rst    = (cnt_q < CNT_W'(RST_CYCLES));
  // Lock modeled as a fixed delay after the PLL reset ends
  assign link_ready = (cnt_q == CNT_W'(DONE_COUNT));

endmodule

`default_nettype wire

// ==== hw/trg_tx_pkg.sv ====
`default_nettype none

`include "trg_link_defs.svh"

package trg_tx_pkg;

  // Data of one 16-bit lane character
  typedef logic [15:0] tx_word_t;

  // Lane character with its K flags
  typedef struct packed {
    tx_word_t   data;    // High byte goes out first
    logic [1:0] isk;     // K flag per byte, high byte first
  } tx_char_t;

  // All lanes side by side, lane 0 in the low slot
  typedef tx_char_t [`TRG_LANES-1:0] lane_bus_t;

  // What a framer is putting on its lane this character
  typedef enum logic [1:0] {
    idle,                // Commas only
    header,              // Header byte plus first payload byte
    body                 // Plain payload characters
  } frame_state_e;

endpackage

`default_nettype wire

// ==== hw/gem_cluster_pkg.sv ====
`default_nettype none

`include "trg_link_defs.svh"

package gem_cluster_pkg;

  // Cluster finder output word, one per cluster slot
  typedef logic [13:0] cluster_t;

  // Bunch-crossing number from the BX counter
  typedef logic [11:0] bxn_t;

  // One side's four clusters, cluster 3 of that side on top
  typedef logic [$bits(cluster_t)*`TRG_CLUSTERS/2-1:0] link_payload_t;

  // Everything the cluster finder offers for one crossing
  typedef struct packed {
    logic                              overflow; // More clusters than slots
    bxn_t                              bxn;      // Crossing the set belongs to
    cluster_t [`TRG_CLUSTERS-1:0]      cluster;  // Slots 0..3 right, 4..7 left
  } cluster_set_t;

endpackage

`default_nettype wire

// ==== hw/trg_link_defs.svh ====
`ifndef TRG_LINK_DEFS_SVH
`define TRG_LINK_DEFS_SVH

// ---------------------------------------------------------------------------
// Link geometry
// ---------------------------------------------------------------------------
`define TRG_CLUSTERS        8        // Cluster words per crossing
`define TRG_LANES           4        // CSC right/left, GEM right/left
`define TRG_WORDS_PER_BX    4        // 16-bit characters per frame

// ---------------------------------------------------------------------------
// Timing
// ---------------------------------------------------------------------------
`define TRG_SYNC_PERIOD     128      // Crossings between comma headers
`define TRG_PLL_RST_CYCLES  15       // PLL reset length after arst_n release
`define TRG_PLL_LOCK_CYCLES 16       // Modeled lock time after PLL reset

// K28.5, the frame comma
`define TRG_COMMA           8'hBC

`endif
